// ==== bench/decode_vectors.svh ====
// decode vector table, included inside the testbench module
// columns: word, bpred, flush, subst {rd,rs1,rs2}, imm, we, w_sel, rs1_sel, rs2_sel, op, unit,
//          change_pc, illegal
// codes: w_sel alu=0 mem=1 br=2; rs1_sel reg=0 pc=1 zero=2; rs2_sel reg=0 imm=1
// codes: op in alu_op_t order (add=0 .. sraw=14); unit alu=0 br=1 mem=2 sys=3
task automatic load_vectors();
    // register forms
    add_vec(32'h003100B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 0, 0, 0, 0);
    add_vec(32'h403100B3, 1, 0, 3'b111, 64'h0, 1, 0, 0, 0, 1, 0, 0, 0);
    add_vec(32'h003110B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 2, 0, 0, 0);
    add_vec(32'h003120B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 3, 0, 0, 0);
    add_vec(32'h003130B3, 1, 0, 3'b111, 64'h0, 1, 0, 0, 0, 4, 0, 0, 0);
    add_vec(32'h003140B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 5, 0, 0, 0);
    add_vec(32'h003150B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 6, 0, 0, 0);
    add_vec(32'h403150B3, 1, 0, 3'b111, 64'h0, 1, 0, 0, 0, 7, 0, 0, 0);
    add_vec(32'h003160B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 8, 0, 0, 0);
    add_vec(32'h003170B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 9, 0, 0, 0);
    add_vec(32'h023100B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 0, 0, 0, 1);
    add_vec(32'h203150B3, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 0, 0, 0, 1);
    // immediate forms, shamt 33 checks the 6 bit RV64 shift amount
    add_vec(32'h00510093, 0, 0, 3'b110, 64'h5, 1, 0, 0, 1, 0, 0, 0, 0);
    add_vec(32'hFFF10093, 1, 0, 3'b110, 64'hFFFFFFFFFFFFFFFF, 1, 0, 0, 1, 0, 0, 0, 0);
    add_vec(32'h00712093, 0, 0, 3'b110, 64'h7, 1, 0, 0, 1, 3, 0, 0, 0);
    add_vec(32'h7FF13093, 0, 0, 3'b110, 64'h7FF, 1, 0, 0, 1, 4, 0, 0, 0);
    add_vec(32'hFFE14093, 0, 0, 3'b110, 64'hFFFFFFFFFFFFFFFE, 1, 0, 0, 1, 5, 0, 0, 0);
    add_vec(32'h003100B3, 0, 1, 3'b111, 64'h0, 1, 0, 0, 0, 0, 0, 0, 0);
    add_vec(32'h01016093, 0, 0, 3'b110, 64'h10, 1, 0, 0, 1, 8, 0, 0, 0);
    add_vec(32'h0FF17093, 1, 0, 3'b110, 64'hFF, 1, 0, 0, 1, 9, 0, 0, 0);
    add_vec(32'h00311093, 0, 0, 3'b110, 64'h3, 1, 0, 0, 1, 2, 0, 0, 0);
    add_vec(32'h02111093, 0, 0, 3'b110, 64'h21, 1, 0, 0, 1, 2, 0, 0, 0);
    add_vec(32'h00415093, 0, 0, 3'b110, 64'h4, 1, 0, 0, 1, 6, 0, 0, 0);
    add_vec(32'h40415093, 0, 0, 3'b110, 64'h404, 1, 0, 0, 1, 7, 0, 0, 0);
    add_vec(32'h40311093, 0, 0, 3'b110, 64'h403, 1, 0, 0, 1, 2, 0, 0, 1);
    add_vec(32'h20415093, 0, 0, 3'b110, 64'h204, 1, 0, 0, 1, 0, 0, 0, 1);
    // upper immediates, jumps, branches, memory
    add_vec(32'h123450B7, 0, 0, 3'b100, 64'h12345000, 1, 0, 2, 1, 0, 0, 0, 0);
    add_vec(32'h800000B7, 0, 0, 3'b100, 64'hFFFFFFFF80000000, 1, 0, 2, 1, 0, 0, 0, 0);
    add_vec(32'hFFFFF097, 1, 0, 3'b100, 64'hFFFFFFFFFFFFF000, 1, 0, 1, 1, 0, 0, 0, 0);
    add_vec(32'h008000EF, 1, 0, 3'b100, 64'h8, 1, 2, 1, 0, 0, 1, 1, 0);
    add_vec(32'hFFDFF0EF, 0, 0, 3'b100, 64'hFFFFFFFFFFFFFFFC, 1, 2, 1, 0, 0, 1, 1, 0);
    add_vec(32'hFF8100E7, 0, 0, 3'b110, 64'hFFFFFFFFFFFFFFF8, 1, 2, 0, 0, 0, 1, 1, 0);
    add_vec(32'h00310863, 1, 0, 3'b011, 64'h10, 0, 0, 0, 0, 0, 1, 0, 0);
    add_vec(32'hFE310FE3, 0, 0, 3'b011, 64'hFFFFFFFFFFFFFFFE, 0, 0, 0, 0, 0, 1, 0, 0);
    add_vec(32'h01013083, 0, 0, 3'b110, 64'h10, 1, 1, 0, 1, 0, 2, 0, 0);
    add_vec(32'hFF013083, 0, 0, 3'b110, 64'hFFFFFFFFFFFFFFF0, 1, 1, 0, 1, 0, 2, 0, 0);
    add_vec(32'h00313423, 0, 0, 3'b011, 64'h8, 0, 0, 0, 1, 0, 2, 0, 0);
    add_vec(32'hFE313C23, 0, 0, 3'b011, 64'hFFFFFFFFFFFFFFF8, 0, 0, 0, 1, 0, 2, 0, 0);
    // word forms
    add_vec(32'hFFF1009B, 0, 0, 3'b110, 64'hFFFFFFFFFFFFFFFF, 1, 0, 0, 1, 10, 0, 0, 0);
    add_vec(32'h0051109B, 0, 0, 3'b110, 64'h5, 1, 0, 0, 1, 12, 0, 0, 0);
    add_vec(32'h0051509B, 0, 0, 3'b110, 64'h5, 1, 0, 0, 1, 13, 0, 0, 0);
    add_vec(32'h4051509B, 0, 0, 3'b110, 64'h405, 1, 0, 0, 1, 14, 0, 0, 0);
    add_vec(32'h0051209B, 0, 0, 3'b110, 64'h5, 1, 0, 0, 1, 0, 0, 0, 1);
    add_vec(32'h003100BB, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 10, 0, 0, 0);
    add_vec(32'h403100BB, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 11, 0, 0, 0);
    add_vec(32'h003110BB, 0, 1, 3'b111, 64'h0, 1, 0, 0, 0, 12, 0, 0, 0);
    add_vec(32'h003110BB, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 12, 0, 0, 0);
    add_vec(32'h003150BB, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 13, 0, 0, 0);
    add_vec(32'h403150BB, 1, 0, 3'b111, 64'h0, 1, 0, 0, 0, 14, 0, 0, 0);
    add_vec(32'h003140BB, 0, 0, 3'b111, 64'h0, 1, 0, 0, 0, 0, 0, 0, 1);
    // system class and unknown opcodes
    add_vec(32'h0FF0000F, 0, 0, 3'b000, 64'h0, 0, 0, 0, 0, 0, 3, 0, 0);
    add_vec(32'h00000073, 0, 0, 3'b000, 64'h0, 0, 0, 0, 0, 0, 3, 0, 0);
    add_vec(32'h80000073, 0, 0, 3'b000, 64'hFFFFFFFFFFFFF800, 0, 0, 0, 0, 0, 3, 0, 0);
    add_vec(32'h0000007F, 0, 0, 3'b000, 64'h0, 0, 0, 0, 0, 0, 0, 0, 1);
    add_vec(32'h00000000, 1, 0, 3'b000, 64'h0, 0, 0, 0, 0, 0, 0, 0, 1);
endtask

// ==== bench/tb_decode.sv ====
// table-driven testbench for decode_top
// outputs are sampled on the falling edge, inputs driven 1 unit after the rising edge
// register fields and PCs are randomized, so expected rd/rs1/rs2 come from the final word
module tb_decode;

    logic               clk_i;
    logic               rst_n_i;
    logic               valid_i;
    logic               flush_i;
    drac_pkg::addr_t    pc_i;
    drac_pkg::inst_t    inst_i;
    logic               bpred_i;
    logic               valid_o;
    drac_pkg::addr_t    pc_o;
    logic               bpred_o;
    drac_pkg::reg_t     rs1_o;
    drac_pkg::reg_t     rs2_o;
    drac_pkg::reg_t     rd_o;
    drac_pkg::data64_t  imm_o;
    logic               regfile_we_o;
    drac_pkg::reg_sel_t regfile_w_sel_o;
    drac_pkg::rs1_sel_t alu_rs1_sel_o;
    drac_pkg::rs2_sel_t alu_rs2_sel_o;
    drac_pkg::alu_op_t  alu_op_o;
    drac_pkg::unit_t    unit_o;
    logic               change_pc_ena_o;
    logic               illegal_o;

    // vector table
    drac_pkg::inst_t    t_word[$];
    bit                 t_bpred[$];
    bit                 t_flush[$];
    bit [2:0]           t_subst[$];
    drac_pkg::data64_t  t_imm[$];
    bit                 t_we[$];
    drac_pkg::reg_sel_t t_wsel[$];
    drac_pkg::rs1_sel_t t_s1[$];
    drac_pkg::rs2_sel_t t_s2[$];
    drac_pkg::alu_op_t  t_op[$];
    drac_pkg::unit_t    t_unit[$];
    bit                 t_cpc[$];
    bit                 t_ill[$];

    // outstanding instructions in issue order
    int                 exp_idx[$];
    drac_pkg::inst_t    exp_word[$];
    drac_pkg::addr_t    exp_pc[$];
    int                 exp_cycle[$];

    int                 pass_count;
    int                 fail_count;
    int                 cycle_count;
    logic [31:0]        rng_state;

    decode_top dut0 (.*);

    task automatic add_vec(input logic [31:0] word, input bit bpred, input bit flush,
                           input bit [2:0] subst, input logic [63:0] imm, input bit we,
                           input int wsel, input int s1, input int s2, input int op,
                           input int unit, input bit cpc, input bit ill);
        t_word.push_back(word);
        t_bpred.push_back(bpred);
        t_flush.push_back(flush);
        t_subst.push_back(subst);
        t_imm.push_back(imm);
        t_we.push_back(we);
        t_wsel.push_back(drac_pkg::reg_sel_t'(wsel));
        t_s1.push_back(drac_pkg::rs1_sel_t'(s1));
        t_s2.push_back(drac_pkg::rs2_sel_t'(s2));
        t_op.push_back(drac_pkg::alu_op_t'(op));
        t_unit.push_back(drac_pkg::unit_t'(unit));
        t_cpc.push_back(cpc);
        t_ill.push_back(ill);
    endtask

    `include "decode_vectors.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v, inout bit ok);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: expected %h, got %h", name, exp_v, act_v);
            ok = 1'b0;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // rising edges since time zero
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // watchdog limit scales with the table length
    initial begin
        #1;
        repeat (t_word.size() * 8 + 10) @(posedge clk_i);
        $display("error: timeout with %0d decoded results never seen", exp_word.size());
        $display("Test failed");
        $finish;
    end

    // each valid_o pulse is checked against the oldest outstanding entry
    initial begin
        int              idx;
        int              cyc;
        drac_pkg::inst_t w;
        drac_pkg::addr_t pc;
        bit              ok;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && valid_o) begin
                if (exp_word.size() == 0) begin
                    $display("error: valid_o pulse with no instruction outstanding");
                    fail_count++;
                end else begin
                    idx = exp_idx.pop_front();
                    w   = exp_word.pop_front();
                    pc  = exp_pc.pop_front();
                    cyc = exp_cycle.pop_front();
                    ok  = 1'b1;
                    if (cycle_count != cyc) begin
                        $display("error: vector %0d reached valid_o at cycle %0d, expected %0d",
                                 idx, cycle_count, cyc);
                        ok = 1'b0;
                    end
                    compare_field("pc_o", pc, pc_o, ok);
                    compare_field("bpred_o", 64'(t_bpred[idx]), 64'(bpred_o), ok);
                    compare_field("rd_o", 64'(w[11:7]), 64'(rd_o), ok);
                    compare_field("rs1_o", 64'(w[19:15]), 64'(rs1_o), ok);
                    compare_field("rs2_o", 64'(w[24:20]), 64'(rs2_o), ok);
                    compare_field("imm_o", t_imm[idx], imm_o, ok);
                    compare_field("regfile_we_o", 64'(t_we[idx]), 64'(regfile_we_o), ok);
                    compare_field("regfile_w_sel_o", 64'(t_wsel[idx]), 64'(regfile_w_sel_o), ok);
                    compare_field("alu_rs1_sel_o", 64'(t_s1[idx]), 64'(alu_rs1_sel_o), ok);
                    compare_field("alu_rs2_sel_o", 64'(t_s2[idx]), 64'(alu_rs2_sel_o), ok);
                    compare_field("alu_op_o", 64'(t_op[idx]), 64'(alu_op_o), ok);
                    compare_field("unit_o", 64'(t_unit[idx]), 64'(unit_o), ok);
                    compare_field("change_pc_ena_o", 64'(t_cpc[idx]), 64'(change_pc_ena_o), ok);
                    compare_field("illegal_o", 64'(t_ill[idx]), 64'(illegal_o), ok);
                    if (ok) begin
                        pass_count++;
                        $display("vector %0d word %h: ok", idx, w);
                    end else begin
                        fail_count++;
                        $display("vector %0d word %h: FAIL", idx, w);
                    end
                end
            end
        end
    end

    initial begin
        drac_pkg::inst_t w;
        drac_pkg::addr_t pc;
        bit              ok;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        rng_state   = 32'd90;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        flush_i     = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        bpred_i     = 1'b0;
        load_vectors();

        repeat (10) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        // outputs after reset and before any strobe
        @(negedge clk_i);
        ok = 1'b1;
        compare_field("valid_o", 64'h0, 64'(valid_o), ok);
        compare_field("pc_o", 64'h0, pc_o, ok);
        compare_field("bpred_o", 64'h0, 64'(bpred_o), ok);
        compare_field("rs1_o", 64'h0, 64'(rs1_o), ok);
        compare_field("rs2_o", 64'h0, 64'(rs2_o), ok);
        compare_field("rd_o", 64'h0, 64'(rd_o), ok);
        compare_field("imm_o", 64'h0, imm_o, ok);
        compare_field("regfile_we_o", 64'h0, 64'(regfile_we_o), ok);
        compare_field("regfile_w_sel_o", 64'h0, 64'(regfile_w_sel_o), ok);
        compare_field("alu_rs1_sel_o", 64'h0, 64'(alu_rs1_sel_o), ok);
        compare_field("alu_rs2_sel_o", 64'h0, 64'(alu_rs2_sel_o), ok);
        compare_field("alu_op_o", 64'h0, 64'(alu_op_o), ok);
        compare_field("unit_o", 64'h0, 64'(unit_o), ok);
        compare_field("change_pc_ena_o", 64'h0, 64'(change_pc_ena_o), ok);
        compare_field("illegal_o", 64'h0, 64'(illegal_o), ok);
        if (ok) begin
            pass_count++;
            $display("reset state: ok");
        end else begin
            fail_count++;
            $display("reset state: FAIL");
        end

        for (int i = 0; i < t_word.size(); i++) begin
            w = t_word[i];
            rng_state = xorshift(rng_state);
            if (t_subst[i][2]) w[11:7] = rng_state[4:0];
            if (t_subst[i][1]) w[19:15] = rng_state[9:5];
            if (t_subst[i][0]) w[24:20] = rng_state[14:10];
            rng_state = xorshift(rng_state);
            pc = {32'h0, rng_state[31:2], 2'b00};
            @(posedge clk_i);
            #1;
            valid_i = 1'b1;
            flush_i = t_flush[i];
            inst_i  = w;
            pc_i    = pc;
            bpred_i = t_bpred[i];
            if (!t_flush[i]) begin
                exp_idx.push_back(i);
                exp_word.push_back(w);
                exp_pc.push_back(pc);
                // sampled on the next edge, registered out on the one after
                exp_cycle.push_back(cycle_count + 2);
            end
            // idle cycle after every eighth entry
            if (i % 8 == 7) begin
                @(posedge clk_i);
                #1;
                valid_i = 1'b0;
                flush_i = 1'b0;
            end
        end
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        flush_i = 1'b0;

        while (exp_word.size() != 0) begin
            @(posedge clk_i);
        end
        // catch any extra pulse
        repeat (4) @(posedge clk_i);
        #1;
        $display("passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== source/decode_stage.sv ====
// decode pipeline stage: input register, decoder, output register
// fixed latency of two edges, no back-pressure
// flush clears the valid bit captured at the same edge
module decode_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  logic               flush_i,
    input  drac_pkg::addr_t    pc_i,
    input  drac_pkg::inst_t    inst_i,
    input  logic               bpred_i,
    output logic               valid_o,
    output drac_pkg::addr_t    pc_o,
    output logic               bpred_o,
    output drac_pkg::reg_t     rs1_o,
    output drac_pkg::reg_t     rs2_o,
    output drac_pkg::reg_t     rd_o,
    output drac_pkg::data64_t  imm_o,
    output logic               regfile_we_o,
    output drac_pkg::reg_sel_t regfile_w_sel_o,
    output drac_pkg::rs1_sel_t alu_rs1_sel_o,
    output drac_pkg::rs2_sel_t alu_rs2_sel_o,
    output drac_pkg::alu_op_t  alu_op_o,
    output drac_pkg::unit_t    unit_o,
    output logic               change_pc_ena_o,
    output logic               illegal_o
);

    logic               valid_q;
    drac_pkg::addr_t    pc_q;
    drac_pkg::inst_t    inst_q;
    logic               bpred_q;

    drac_pkg::reg_t     dec_rs1;
    drac_pkg::reg_t     dec_rs2;
    drac_pkg::reg_t     dec_rd;
    drac_pkg::data64_t  dec_imm;
    logic               dec_we;
    drac_pkg::reg_sel_t dec_w_sel;
    drac_pkg::rs1_sel_t dec_rs1_sel;
    drac_pkg::rs2_sel_t dec_rs2_sel;
    drac_pkg::alu_op_t  dec_alu_op;
    drac_pkg::unit_t    dec_unit;
    logic               dec_change_pc;
    logic               dec_illegal;

    // input register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            inst_q  <= '0;
            bpred_q <= 1'b0;
        end else begin
            valid_q <= valid_i && !flush_i;
            if (valid_i) begin
                pc_q    <= pc_i;
                inst_q  <= inst_i;
                bpred_q <= bpred_i;
            end
        end
    end

    decoder decoder0 (
        .inst_i          (inst_q),
        .rs1_o           (dec_rs1),
        .rs2_o           (dec_rs2),
        .rd_o            (dec_rd),
        .imm_o           (dec_imm),
        .regfile_we_o    (dec_we),
        .regfile_w_sel_o (dec_w_sel),
        .alu_rs1_sel_o   (dec_rs1_sel),
        .alu_rs2_sel_o   (dec_rs2_sel),
        .alu_op_o        (dec_alu_op),
        .unit_o          (dec_unit),
        .change_pc_ena_o (dec_change_pc),
        .illegal_o       (dec_illegal)
    );

    // output register, holds its contents between strobes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o         <= 1'b0;
            pc_o            <= '0;
            bpred_o         <= 1'b0;
            rs1_o           <= '0;
            rs2_o           <= '0;
            rd_o            <= '0;
            imm_o           <= '0;
            regfile_we_o    <= 1'b0;
            regfile_w_sel_o <= drac_pkg::SEL_FROM_ALU;
            alu_rs1_sel_o   <= drac_pkg::SEL_SRC1_REGFILE;
            alu_rs2_sel_o   <= drac_pkg::SEL_SRC2_REGFILE;
            alu_op_o        <= drac_pkg::ALU_ADD;
            unit_o          <= drac_pkg::UNIT_ALU;
            change_pc_ena_o <= 1'b0;
            illegal_o       <= 1'b0;
        end else begin
            valid_o <= valid_q;
            if (valid_q) begin
                pc_o            <= pc_q;
                bpred_o         <= bpred_q;
                rs1_o           <= dec_rs1;
                rs2_o           <= dec_rs2;
                rd_o            <= dec_rd;
                imm_o           <= dec_imm;
                regfile_we_o    <= dec_we;
                regfile_w_sel_o <= dec_w_sel;
                alu_rs1_sel_o   <= dec_rs1_sel;
                alu_rs2_sel_o   <= dec_rs2_sel;
                alu_op_o        <= dec_alu_op;
                unit_o          <= dec_unit;
                change_pc_ena_o <= dec_change_pc;
                illegal_o       <= dec_illegal;
            end
        end
    end

endmodule

// ==== source/decode_top.sv ====
// top level of the decode subsystem
// a new instruction may be strobed every cycle; results follow two edges later
module decode_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  logic               flush_i,
    input  drac_pkg::addr_t    pc_i,
    input  drac_pkg::inst_t    inst_i,
    input  logic               bpred_i,
    output logic               valid_o,
    output drac_pkg::addr_t    pc_o,
    output logic               bpred_o,
    output drac_pkg::reg_t     rs1_o,
    output drac_pkg::reg_t     rs2_o,
    output drac_pkg::reg_t     rd_o,
    output drac_pkg::data64_t  imm_o,
    output logic               regfile_we_o,
    output drac_pkg::reg_sel_t regfile_w_sel_o,
    output drac_pkg::rs1_sel_t alu_rs1_sel_o,
    output drac_pkg::rs2_sel_t alu_rs2_sel_o,
    output drac_pkg::alu_op_t  alu_op_o,
    output drac_pkg::unit_t    unit_o,
    output logic               change_pc_ena_o,
    output logic               illegal_o
);

    decode_stage decode_stage0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .flush_i         (flush_i),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .bpred_i         (bpred_i),
        .valid_o         (valid_o),
        .pc_o            (pc_o),
        .bpred_o         (bpred_o),
        .rs1_o           (rs1_o),
        .rs2_o           (rs2_o),
        .rd_o            (rd_o),
        .imm_o           (imm_o),
        .regfile_we_o    (regfile_we_o),
        .regfile_w_sel_o (regfile_w_sel_o),
        .alu_rs1_sel_o   (alu_rs1_sel_o),
        .alu_rs2_sel_o   (alu_rs2_sel_o),
        .alu_op_o        (alu_op_o),
        .unit_o          (unit_o),
        .change_pc_ena_o (change_pc_ena_o),
        .illegal_o       (illegal_o)
    );

endmodule

// ==== source/decoder.sv ====
// combinational RV64I decoder, one instruction at a time
// CSR and FENCE semantics are not decoded, only their unit class
// illegal encodings raise illegal_o; other outputs still follow the opcode
module decoder (
    input  drac_pkg::inst_t   inst_i,
    output drac_pkg::reg_t    rs1_o,
    output drac_pkg::reg_t    rs2_o,
    output drac_pkg::reg_t    rd_o,
    output drac_pkg::data64_t imm_o,
    output logic              regfile_we_o,
    output drac_pkg::reg_sel_t regfile_w_sel_o,
    output drac_pkg::rs1_sel_t alu_rs1_sel_o,
    output drac_pkg::rs2_sel_t alu_rs2_sel_o,
    output drac_pkg::alu_op_t alu_op_o,
    output drac_pkg::unit_t   unit_o,
    output logic              change_pc_ena_o,
    output logic              illegal_o
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    // RV64 shift immediates use a 6 bit shamt, so only bits 31:26 qualify
    logic [5:0] func6;

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];
    assign func6  = inst_i[31:26];

    // register indices are the raw fields
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    immediate immediate0 (
        .inst_i (inst_i),
        .imm_o  (imm_o)
    );

    always_comb begin
        regfile_we_o    = 1'b0;
        regfile_w_sel_o = drac_pkg::SEL_FROM_ALU;
        alu_rs1_sel_o   = drac_pkg::SEL_SRC1_REGFILE;
        alu_rs2_sel_o   = drac_pkg::SEL_SRC2_REGFILE;
        alu_op_o        = drac_pkg::ALU_ADD;
        unit_o          = drac_pkg::UNIT_ALU;
        change_pc_ena_o = 1'b0;
        illegal_o       = 1'b0;

        case (opcode)
            drac_pkg::OP_LUI: begin
                regfile_we_o  = 1'b1;
                alu_rs1_sel_o = drac_pkg::SEL_SRC1_ZERO;
                alu_rs2_sel_o = drac_pkg::SEL_SRC2_IMM;
            end
            drac_pkg::OP_AUIPC: begin
                regfile_we_o  = 1'b1;
                alu_rs1_sel_o = drac_pkg::SEL_SRC1_PC;
                alu_rs2_sel_o = drac_pkg::SEL_SRC2_IMM;
            end
            drac_pkg::OP_JAL, drac_pkg::OP_JALR: begin
                // link value comes back through the branch unit
                regfile_we_o    = 1'b1;
                regfile_w_sel_o = drac_pkg::SEL_FROM_BRANCH;
                unit_o          = drac_pkg::UNIT_BRANCH;
                change_pc_ena_o = 1'b1;
                if (opcode == drac_pkg::OP_JAL) begin
                    alu_rs1_sel_o = drac_pkg::SEL_SRC1_PC;
                end
            end
            drac_pkg::OP_BRANCH: begin
                unit_o = drac_pkg::UNIT_BRANCH;
            end
            drac_pkg::OP_LOAD: begin
                regfile_we_o    = 1'b1;
                regfile_w_sel_o = drac_pkg::SEL_FROM_MEM;
                unit_o          = drac_pkg::UNIT_MEM;
                alu_rs2_sel_o   = drac_pkg::SEL_SRC2_IMM;
            end
            drac_pkg::OP_STORE: begin
                unit_o        = drac_pkg::UNIT_MEM;
                alu_rs2_sel_o = drac_pkg::SEL_SRC2_IMM;
            end
            drac_pkg::OP_ALU_I: begin
                regfile_we_o  = 1'b1;
                alu_rs2_sel_o = drac_pkg::SEL_SRC2_IMM;
                case (func3)
                    drac_pkg::F3_ADDI:  alu_op_o = drac_pkg::ALU_ADD;
                    drac_pkg::F3_SLTI:  alu_op_o = drac_pkg::ALU_SLT;
                    drac_pkg::F3_SLTIU: alu_op_o = drac_pkg::ALU_SLTU;
                    drac_pkg::F3_XORI:  alu_op_o = drac_pkg::ALU_XOR;
                    drac_pkg::F3_ORI:   alu_op_o = drac_pkg::ALU_OR;
                    drac_pkg::F3_ANDI:  alu_op_o = drac_pkg::ALU_AND;
                    drac_pkg::F3_SLLI: begin
                        alu_op_o  = drac_pkg::ALU_SLL;
                        illegal_o = (func6 != drac_pkg::F7_NORMAL[6:1]);
                    end
                    default: begin
                        if (func6 == drac_pkg::F7_SRAI_SUB_SRA[6:1]) begin
                            alu_op_o = drac_pkg::ALU_SRA;
                        end else if (func6 == drac_pkg::F7_NORMAL[6:1]) begin
                            alu_op_o = drac_pkg::ALU_SRL;
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                endcase
            end
            drac_pkg::OP_ALU: begin
                regfile_we_o = 1'b1;
                case (func3)
                    drac_pkg::F3_SLL:  alu_op_o = drac_pkg::ALU_SLL;
                    drac_pkg::F3_SLT:  alu_op_o = drac_pkg::ALU_SLT;
                    drac_pkg::F3_SLTU: alu_op_o = drac_pkg::ALU_SLTU;
                    drac_pkg::F3_XOR:  alu_op_o = drac_pkg::ALU_XOR;
                    drac_pkg::F3_OR:   alu_op_o = drac_pkg::ALU_OR;
                    drac_pkg::F3_AND:  alu_op_o = drac_pkg::ALU_AND;
                    drac_pkg::F3_ADD_SUB: begin
                        if (func7 == drac_pkg::F7_SRAI_SUB_SRA) begin
                            alu_op_o = drac_pkg::ALU_SUB;
                        end else if (func7 != drac_pkg::F7_NORMAL) begin
                            illegal_o = 1'b1;
                        end
                    end
                    default: begin
                        if (func7 == drac_pkg::F7_SRAI_SUB_SRA) begin
                            alu_op_o = drac_pkg::ALU_SRA;
                        end else if (func7 == drac_pkg::F7_NORMAL) begin
                            alu_op_o = drac_pkg::ALU_SRL;
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                endcase
            end
            drac_pkg::OP_ALU_I_W, drac_pkg::OP_ALU_W: begin
                regfile_we_o = 1'b1;
                if (opcode == drac_pkg::OP_ALU_I_W) begin
                    alu_rs2_sel_o = drac_pkg::SEL_SRC2_IMM;
                end
                case (func3)
                    drac_pkg::F3_ADD_SUB: begin
                        // ADDIW has no func7 field, its top bits are immediate
                        if (opcode == drac_pkg::OP_ALU_I_W || func7 == drac_pkg::F7_NORMAL) begin
                            alu_op_o = drac_pkg::ALU_ADDW;
                        end else if (func7 == drac_pkg::F7_SRAI_SUB_SRA) begin
                            alu_op_o = drac_pkg::ALU_SUBW;
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                    drac_pkg::F3_SLL: begin
                        alu_op_o  = drac_pkg::ALU_SLLW;
                        illegal_o = (func7 != drac_pkg::F7_NORMAL);
                    end
                    drac_pkg::F3_SRL_SRA: begin
                        if (func7 == drac_pkg::F7_SRAI_SUB_SRA) begin
                            alu_op_o = drac_pkg::ALU_SRAW;
                        end else if (func7 == drac_pkg::F7_NORMAL) begin
                            alu_op_o = drac_pkg::ALU_SRLW;
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                    default: begin
                        illegal_o = 1'b1;
                    end
                endcase
            end
            drac_pkg::OP_FENCE, drac_pkg::OP_SYSTEM: begin
                unit_o = drac_pkg::UNIT_SYSTEM;
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/drac_pkg.sv ====
// shared types and encodings for the RV64I decode path
// only base-ISA opcodes are listed here; compressed and M-extension are absent
// enums use the narrowest encoding that holds their values
package drac_pkg;

    // widths with a meaning in the core
    typedef logic [63:0] data64_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_t;

    // major opcodes
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_AUIPC   = 7'b0010111;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_JALR    = 7'b1100111;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_ALU_I   = 7'b0010011;
    localparam logic [6:0] OP_ALU     = 7'b0110011;
    localparam logic [6:0] OP_ALU_I_W = 7'b0011011;
    localparam logic [6:0] OP_ALU_W   = 7'b0111011;
    localparam logic [6:0] OP_FENCE   = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

    // func3, immediate forms
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRLAI = 3'b101;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    // func3, register forms (word forms reuse these)
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // func7
    localparam logic [6:0] F7_NORMAL       = 7'b0000000;
    localparam logic [6:0] F7_SRAI_SUB_SRA = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW
    } alu_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM,
        UNIT_SYSTEM
    } unit_t;

    // source of the register file write data
    typedef enum logic [1:0] {
        SEL_FROM_ALU,
        SEL_FROM_MEM,
        SEL_FROM_BRANCH
    } reg_sel_t;

    typedef enum logic [1:0] {
        SEL_SRC1_REGFILE,
        SEL_SRC1_PC,
        SEL_SRC1_ZERO
    } rs1_sel_t;

    typedef enum logic {
        SEL_SRC2_REGFILE,
        SEL_SRC2_IMM
    } rs2_sel_t;

endpackage

// ==== source/immediate.sv ====
// immediate generator for the base integer formats
// FENCE and unknown opcodes give a zero immediate
// every result is sign-extended from instruction bit 31
module immediate (
    input  drac_pkg::inst_t   inst_i,
    output drac_pkg::data64_t imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (inst_i[6:0])
            // I-type
            drac_pkg::OP_JALR, drac_pkg::OP_LOAD, drac_pkg::OP_ALU_I,
            drac_pkg::OP_ALU_I_W, drac_pkg::OP_SYSTEM: begin
                imm_o = {{52{sign}}, inst_i[31:20]};
            end
            // S-type
            drac_pkg::OP_STORE: begin
                imm_o = {{52{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            // B-type, bit 0 always zero
            drac_pkg::OP_BRANCH: begin
                imm_o = {{52{sign}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            // U-type
            drac_pkg::OP_LUI, drac_pkg::OP_AUIPC: begin
                imm_o = {{32{sign}}, inst_i[31:12], 12'b0};
            end
            // J-type
            drac_pkg::OP_JAL: begin
                imm_o = {{44{sign}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== tb.f ====
+incdir+bench
source/drac_pkg.sv
source/immediate.sv
source/decoder.sv
source/decode_stage.sv
source/decode_top.sv
bench/tb_decode.sv
